// File: rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

  // Machine-mode CSR addresses.
  localparam logic [11:0] csr_addr_mstatus   = 12'h300;
  localparam logic [11:0] csr_addr_mtvec     = 12'h305;
  localparam logic [11:0] csr_addr_mepc      = 12'h341;
  localparam logic [11:0] csr_addr_mcause    = 12'h342;
  localparam logic [11:0] csr_addr_mvendorid = 12'hf11;
  localparam logic [11:0] csr_addr_marchid   = 12'hf12;

  localparam logic [31:0] vendor_id_val = 32'h7973_7978;
  localparam logic [31:0] arch_id_val   = 32'h015f_de77;

  localparam int unsigned mstatus_mie_idx  = 3;
  localparam int unsigned mstatus_mpie_idx = 7;

  // Only MIE and MPIE are implemented.
  localparam logic [31:0] mstatus_wmask = (32'd1 << mstatus_mie_idx) |
                                          (32'd1 << mstatus_mpie_idx);

  localparam logic [31:0] cause_ecall_m = 32'd11; // Environment call from M-mode.

  localparam logic [2:0] f3_priv   = 3'b000;
  localparam logic [2:0] f3_csrrw  = 3'b001;
  localparam logic [2:0] f3_csrrs  = 3'b010;
  localparam logic [2:0] f3_csrrc  = 3'b011;
  localparam logic [2:0] f3_csrrwi = 3'b101;
  localparam logic [2:0] f3_csrrsi = 3'b110;
  localparam logic [2:0] f3_csrrci = 3'b111;

  localparam logic [11:0] f12_ecall = 12'h000;
  localparam logic [11:0] f12_mret  = 12'h302;

  typedef struct packed {
    logic [11:0] csr;
    logic [4:0]  rs1; // Register index or uimm.
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } zicsr_instr_t;

  typedef struct packed {
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } priv_instr_t;

  typedef union packed {
    zicsr_instr_t zicsr;
    priv_instr_t  priv;
  } sys_instr_u;

  typedef struct packed {
    logic [31:0] mstatus;
    logic [31:0] mcause;
    logic [31:0] mepc;
    logic [31:0] mtvec;
  } csr_state_t;

  typedef enum logic [2:0] {
    csr_idx_none,
    csr_idx_mstatus,
    csr_idx_mcause,
    csr_idx_mepc,
    csr_idx_mtvec
  } csr_idx_e;

  typedef struct packed {
    logic        en;
    csr_idx_e    idx;
    logic [31:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic        ecall;
    logic        mret;
    logic [31:0] ret_pc;
  } trap_upd_t;

endpackage

`default_nettype wire

// File: rtl/csr_access_unit.sv
`timescale 1ns/100ps
`default_nettype none

module csr_access_unit
  import csr_pkg::*;
(
  input  logic        valid,
  input  sys_instr_u  instr,
  input  logic [31:0] rs1_data,
  input  csr_state_t  state,
  output logic [31:0] rd_data,
  output csr_wr_t     wr
);

  zicsr_instr_t zi;
  logic         is_swap;
  logic         is_set;
  logic         is_clr;
  logic         imm_form;
  logic         zero_src;
  logic [31:0]  operand;
  logic [31:0]  old_val;
  logic [31:0]  new_val;
  csr_idx_e     idx;

  assign zi = instr.zicsr;

  assign is_swap  = (zi.funct3 == f3_csrrw) || (zi.funct3 == f3_csrrwi);
  assign is_set   = (zi.funct3 == f3_csrrs) || (zi.funct3 == f3_csrrsi);
  assign is_clr   = (zi.funct3 == f3_csrrc) || (zi.funct3 == f3_csrrci);
  assign imm_form = (zi.funct3 == f3_csrrwi) || (zi.funct3 == f3_csrrsi) ||
                    (zi.funct3 == f3_csrrci);

  assign operand  = imm_form ? {27'd0, zi.rs1} : rs1_data;
  assign zero_src = (zi.rs1 == 5'd0); // Same field for rs1 and uimm.

  // Old value lookup and write target.
  always_comb begin
    old_val = '0;
    idx     = csr_idx_none;
    case (zi.csr)
      csr_addr_mstatus: begin
        old_val = state.mstatus;
        idx     = csr_idx_mstatus;
      end
      csr_addr_mcause: begin
        old_val = state.mcause;
        idx     = csr_idx_mcause;
      end
      csr_addr_mepc: begin
        old_val = state.mepc;
        idx     = csr_idx_mepc;
      end
      csr_addr_mtvec: begin
        old_val = state.mtvec;
        idx     = csr_idx_mtvec;
      end
      csr_addr_mvendorid: old_val = vendor_id_val;
      csr_addr_marchid:   old_val = arch_id_val;
      default:            old_val = '0; // Unknown CSR reads zero.
    endcase
  end

  always_comb begin
    if (is_swap) begin
      new_val = operand;
    end else if (is_set) begin
      new_val = old_val | operand;
    end else if (is_clr) begin
      new_val = old_val & ~operand;
    end else begin
      new_val = old_val;
    end
  end

  assign rd_data = (zi.funct3 != f3_priv) ? old_val : '0;

  assign wr.en   = valid && (idx != csr_idx_none) &&
                   (is_swap || ((is_set || is_clr) && !zero_src));
  assign wr.idx  = idx;
  assign wr.data = (idx == csr_idx_mstatus) ? (new_val & mstatus_wmask) : new_val;

endmodule

`default_nettype wire

// File: rtl/trap_unit.sv
`timescale 1ns/100ps
`default_nettype none

module trap_unit
  import csr_pkg::*;
(
  input  logic        valid,
  input  sys_instr_u  instr,
  input  logic [31:0] pc,
  input  csr_state_t  state,
  output trap_upd_t   upd,
  output logic        redirect,
  output logic [31:0] redirect_pc
);

  priv_instr_t pi;
  logic        is_priv;
  logic        is_ecall;
  logic        is_mret;

  assign pi = instr.priv;

  // Zicsr forms never have funct3 of zero.
  assign is_priv  = valid && (pi.funct3 == f3_priv);
  assign is_ecall = is_priv && (pi.funct12 == f12_ecall);
  assign is_mret  = is_priv && (pi.funct12 == f12_mret);

  assign upd.ecall  = is_ecall;
  assign upd.mret   = is_mret;
  assign upd.ret_pc = pc; // Saved to mepc on ecall.

  assign redirect = is_ecall || is_mret;

  // Targets come from state before this edge.
  always_comb begin
    if (is_ecall) begin
      redirect_pc = state.mtvec;
    end else if (is_mret) begin
      redirect_pc = state.mepc;
    end else begin
      redirect_pc = '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/csr_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module csr_regfile
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  csr_wr_t    wr,
  input  trap_upd_t  upd,
  output csr_state_t state
);

  csr_state_t state_d;
  logic       old_mie;
  logic       old_mpie;

  assign old_mie  = state.mstatus[mstatus_mie_idx];
  assign old_mpie = state.mstatus[mstatus_mpie_idx];

  // Next state. Write and trap update are exclusive by funct3.
  always_comb begin
    state_d = state;
    if (wr.en) begin
      case (wr.idx)
        csr_idx_mstatus: state_d.mstatus = wr.data;
        csr_idx_mcause:  state_d.mcause  = wr.data;
        csr_idx_mepc:    state_d.mepc    = wr.data;
        csr_idx_mtvec:   state_d.mtvec   = wr.data;
        default:         state_d         = state;
      endcase
    end else if (upd.ecall) begin
      state_d.mepc                      = upd.ret_pc;
      state_d.mcause                    = cause_ecall_m;
      state_d.mstatus[mstatus_mpie_idx] = old_mie;
      state_d.mstatus[mstatus_mie_idx]  = 1'b0;
    end else if (upd.mret) begin
      state_d.mstatus[mstatus_mie_idx]  = old_mpie;
      state_d.mstatus[mstatus_mpie_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= '0;
    end else begin
      state <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/csr_exu_top.sv
`timescale 1ns/100ps
`default_nettype none

module csr_exu_top
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        valid,
  input  sys_instr_u  instr,
  input  logic [31:0] rs1_data,
  input  logic [31:0] pc,
  output logic [31:0] rd_data,
  output logic        redirect,
  output logic [31:0] redirect_pc,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);

  csr_state_t state;
  csr_wr_t    wr;
  trap_upd_t  upd;

  csr_access_unit u_access (
    .valid    (valid),
    .instr    (instr),
    .rs1_data (rs1_data),
    .state    (state),
    .rd_data  (rd_data),
    .wr       (wr)
  );

  trap_unit u_trap (
    .valid       (valid),
    .instr       (instr),
    .pc          (pc),
    .state       (state),
    .upd         (upd),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  csr_regfile u_regfile (
    .clk   (clk),
    .rst   (rst),
    .wr    (wr),
    .upd   (upd),
    .state (state)
  );

  assign mtvec = state.mtvec;
  assign mepc  = state.mepc;

endmodule

`default_nettype wire

// File: verif/csr_tb.sv
`timescale 1ns/100ps
`default_nettype none

module csr_tb
  import csr_pkg::*;
();

  localparam int test_cycles = 5 + 6 + 200 + 26 + 120 + 40 + 111;
  localparam int margin      = 200;

  logic        clk = 1'b0;
  logic        rst;
  logic        valid;
  sys_instr_u  instr;
  logic [31:0] rs1_data;
  logic [31:0] pc;
  logic [31:0] rd_data;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic [31:0] mtvec;
  logic [31:0] mepc;

  logic [31:0] lfsr = 32'h3e42;
  logic [31:0] m_mstatus, m_mcause, m_mepc, m_mtvec; // Expected CSR state.
  string       cur_test;
  int          checks, errors, test_checks, test_errors;

  logic [11:0] wr_addrs [4] = '{csr_addr_mstatus, csr_addr_mcause, csr_addr_mepc, csr_addr_mtvec};
  logic [2:0]  f3_list [6]  = '{f3_csrrw, f3_csrrs, f3_csrrc, f3_csrrwi, f3_csrrsi, f3_csrrci};

  csr_exu_top dut0 (
    .clk, .rst, .valid, .instr, .rs1_data, .pc,
    .rd_data, .redirect, .redirect_pc, .mtvec, .mepc
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic sys_instr_u make_zicsr(input logic [2:0] f3, input logic [11:0] csr,
                                            input logic [4:0] src);
    sys_instr_u u;
    u.zicsr = '{csr: csr, rs1: src, funct3: f3, rd: 5'd1, opcode: 7'h73};
    return u;
  endfunction

  function automatic sys_instr_u make_priv(input logic [11:0] f12);
    sys_instr_u u;
    u.priv = '{funct12: f12, rs1: 5'd0, funct3: f3_priv, rd: 5'd0, opcode: 7'h73};
    return u;
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] csr);
    case (csr)
      csr_addr_mstatus:   return m_mstatus;
      csr_addr_mcause:    return m_mcause;
      csr_addr_mepc:      return m_mepc;
      csr_addr_mtvec:     return m_mtvec;
      csr_addr_mvendorid: return vendor_id_val;
      csr_addr_marchid:   return arch_id_val;
      default:            return 32'd0;
    endcase
  endfunction

  task automatic model_write(input logic [11:0] csr, input logic [31:0] v);
    case (csr)
      csr_addr_mstatus: m_mstatus = v & mstatus_wmask; // Only MIE and MPIE stick.
      csr_addr_mcause:  m_mcause  = v;
      csr_addr_mepc:    m_mepc    = v;
      csr_addr_mtvec:   m_mtvec   = v;
      default:          ;
    endcase
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    test_checks++;
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %s done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
  endtask

  // Drives one instruction and checks it at the falling edge.
  task automatic do_instr(input sys_instr_u ins, input logic [31:0] src, input logic [31:0] pc_v);
    zicsr_instr_t z;
    logic [31:0]  old_v, operand, new_v;
    logic         is_ecall, is_mret, do_wr;
    z = ins.zicsr;
    @(posedge clk);
    valid    <= 1'b1;
    instr    <= ins;
    rs1_data <= src;
    pc       <= pc_v;
    @(negedge clk);
    is_ecall = (z.funct3 == f3_priv) && (ins.priv.funct12 == f12_ecall);
    is_mret  = (z.funct3 == f3_priv) && (ins.priv.funct12 == f12_mret);
    old_v    = model_read(z.csr);
    check_val("rd_data", (z.funct3 == f3_priv) ? 32'd0 : old_v, rd_data);
    check_val("redirect", is_ecall || is_mret, redirect);
    check_val("redirect_pc", is_ecall ? m_mtvec : (is_mret ? m_mepc : 32'd0), redirect_pc);
    check_val("mtvec", m_mtvec, mtvec);
    check_val("mepc", m_mepc, mepc);
    if (z.funct3 != f3_priv) begin
      operand = (z.funct3 inside {f3_csrrwi, f3_csrrsi, f3_csrrci}) ? {27'd0, z.rs1} : src;
      if (z.funct3 inside {f3_csrrw, f3_csrrwi}) begin
        new_v = operand;
        do_wr = 1'b1;
      end else begin
        new_v = (z.funct3 inside {f3_csrrs, f3_csrrsi}) ? (old_v | operand) : (old_v & ~operand);
        do_wr = (z.rs1 != 5'd0);
      end
      if (do_wr) model_write(z.csr, new_v);
    end else if (is_ecall) begin
      m_mepc    = pc_v;
      m_mcause  = cause_ecall_m;
      m_mstatus[mstatus_mpie_idx] = m_mstatus[mstatus_mie_idx];
      m_mstatus[mstatus_mie_idx]  = 1'b0;
    end else if (is_mret) begin
      m_mstatus[mstatus_mie_idx]  = m_mstatus[mstatus_mpie_idx];
      m_mstatus[mstatus_mpie_idx] = 1'b1;
    end
  endtask

  // The presented instruction would change state if valid were ignored.
  task automatic idle_cycle(input sys_instr_u ins, input logic [31:0] src,
                            input logic [31:0] pc_v);
    @(posedge clk);
    valid    <= 1'b0;
    instr    <= ins;
    rs1_data <= src;
    pc       <= pc_v;
    @(negedge clk);
    check_val("redirect", 32'd0, redirect);
    check_val("mtvec", m_mtvec, mtvec);
    check_val("mepc", m_mepc, mepc);
  endtask

  task automatic read_csr(input logic [11:0] csr);
    do_instr(make_zicsr(f3_csrrs, csr, 5'd0), 32'hffff_ffff, 32'd0);
  endtask

  initial begin
    #((test_cycles + margin) * 100);
    $display("Timeout: the run did not finish within %0d cycles", test_cycles + margin);
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [31:0] r, d, p;
    rst = 1'b1;
    valid = 1'b0;
    instr = '0;
    rs1_data = '0;
    pc = '0;
    {m_mstatus, m_mcause, m_mepc, m_mtvec} = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    start_test("reset");
    foreach (wr_addrs[i]) read_csr(wr_addrs[i]);
    read_csr(csr_addr_mvendorid);
    read_csr(csr_addr_marchid);
    end_test();

    start_test("register_writes");
    repeat (200) begin
      rand_bits(2, r);
      rand_bits(3, p);
      rand_bits(32, d);
      do_instr(make_zicsr(f3_list[p % 6], wr_addrs[r], d[4:0]), d, 32'd0);
    end
    end_test();

    start_test("skipped_writes");
    foreach (wr_addrs[i]) begin
      foreach (f3_list[j]) begin
        rand_bits(32, d);
        if (j != 0 && j != 3) do_instr(make_zicsr(f3_list[j], wr_addrs[i], 5'd0), d | 1, 0);
      end
    end
    do_instr(make_zicsr(f3_csrrw, csr_addr_mvendorid, 5'd3), 32'h1234_5678, 32'd0);
    do_instr(make_zicsr(f3_csrrw, csr_addr_marchid, 5'd3), 32'h8765_4321, 32'd0);
    do_instr(make_zicsr(f3_csrrw, 12'h7c0, 5'd3), 32'hdead_beef, 32'd0); // Unknown address.
    read_csr(csr_addr_mvendorid);
    read_csr(csr_addr_marchid);
    read_csr(12'h7c0);
    foreach (wr_addrs[i]) read_csr(wr_addrs[i]);
    end_test();

    start_test("ecall");
    repeat (20) begin
      rand_bits(32, d);
      do_instr(make_zicsr(f3_csrrw, csr_addr_mtvec, 5'd1), d, 32'd0);
      rand_bits(32, d);
      do_instr(make_zicsr(f3_csrrw, csr_addr_mstatus, 5'd1), d, 32'd0);
      rand_bits(32, p);
      do_instr(make_priv(f12_ecall), 32'd0, p);
      read_csr(csr_addr_mepc);
      read_csr(csr_addr_mcause);
      read_csr(csr_addr_mstatus);
    end
    end_test();

    start_test("mret");
    repeat (10) begin
      rand_bits(32, d);
      do_instr(make_zicsr(f3_csrrw, csr_addr_mepc, 5'd1), d, 32'd0);
      rand_bits(32, d);
      do_instr(make_zicsr(f3_csrrw, csr_addr_mstatus, 5'd1), d, 32'd0);
      do_instr(make_priv(f12_mret), 32'd0, 32'd0);
      read_csr(csr_addr_mstatus);
    end
    end_test();

    start_test("idle_back_to_back");
    repeat (10) begin
      rand_bits(32, d);
      do_instr(make_zicsr(f3_csrrw, csr_addr_mtvec, 5'd1), d, 32'd0);
      rand_bits(32, d);
      do_instr(make_zicsr(f3_csrrw, csr_addr_mtvec, 5'd1), d, 32'd0); // Sees previous write.
      rand_bits(3, r);
      repeat (r + 1) begin
        rand_bits(1, p);
        if (p[0]) begin
          idle_cycle(make_priv(f12_ecall), 32'd0, ~m_mepc);
        end else begin
          idle_cycle(make_zicsr(f3_csrrw, csr_addr_mtvec, 5'd1), ~m_mtvec, 32'd0);
        end
      end
      read_csr(csr_addr_mtvec);
    end
    idle_cycle(make_priv(f12_ecall), 32'd0, ~m_mepc);
    end_test();

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
rtl/csr_pkg.sv
rtl/csr_access_unit.sv
rtl/trap_unit.sv
rtl/csr_regfile.sv
rtl/csr_exu_top.sv
verif/csr_tb.sv

// File: Bender.yml
package:
  name: csr_exu

sources:
  - files:
      - rtl/csr_pkg.sv
      - rtl/csr_access_unit.sv
      - rtl/trap_unit.sv
      - rtl/csr_regfile.sv
      - rtl/csr_exu_top.sv
  - target: test
    files:
      - verif/csr_tb.sv
